//--- Bender.yml
package:
  name: ac97_cra

sources:
  - files:
      - hdl/ac97_pkg.sv
      - hdl/ac97_slot_if.sv
      - hdl/ac97_cra.sv
      - hdl/ac97_frame_seq.sv
      - hdl/ac97_sout.sv
      - hdl/ac97_sin.sv
      - hdl/ac97_top.sv
  - target: test
    files:
      - dv/ac97_codec_model.sv
      - dv/ac97_tb.sv

//--- dv/ac97_codec_model.sv
`timescale 1ns/1ps

module ac97_codec_model (
	input logic clk,
	input logic rst,
	input logic sync,
	input logic sdata_out,
	output logic sdata_in,
	output int head_count,				// Frame heads decoded so far
	output logic head_valid,
	output logic head_wr,
	output logic [6:0] head_idx,
	output ac97_pkg::cra_data_t head_data
);

	ac97_pkg::cra_data_t regs [64];		// Even register addresses only
	logic [ac97_pkg::head_bits-1:0] head;
	logic [ac97_pkg::slot_bits-1:0] reply;
	logic sync_d;
	int pos;

	initial
		sdata_in = 1'b0;

	always @(posedge clk)
	begin
		if (!rst)
		begin
			foreach (regs[i])
				regs[i] = '0;
			sync_d = 1'b0;
			pos = -1;
			reply = '0;
			head_count <= 0;
			sdata_in <= 1'b0;
		end
		else
		begin
			if (sync && !sync_d)
				pos = 0;
			else if (pos >= 0)
				pos = pos + 1;
			sync_d = sync;
			if (pos >= 0 && pos < ac97_pkg::head_bits)
				head = {head[ac97_pkg::head_bits-2:0], sdata_out};
			// Slot 1 is in, so a read is answered in slot 2 of this frame
			if (pos == ac97_pkg::slot2_start - 1)
				reply = (head[34] && head[19]) ? {regs[head[18:13]], 4'h0} : '0;
			if (pos >= ac97_pkg::slot2_start - 1 && pos < ac97_pkg::head_bits - 1)
				sdata_in <= reply[ac97_pkg::head_bits - 2 - pos];
			else
				sdata_in <= 1'b0;
			if (pos == ac97_pkg::head_bits - 1)
			begin
				head_count <= head_count + 1;
				head_valid <= head[54];
				head_wr <= head[53];
				head_idx <= head[38:32];
				head_data <= head[19:4];
				if (head[54] && head[53] && !head[39])
					regs[head[38:33]] = head[19:4];	// Write frame
			end
		end
	end

endmodule

//--- dv/ac97_tb.sv
`timescale 1ns/1ps

module ac97_tb;

	typedef struct
	{
		string name;
		ac97_pkg::cra_op_t op;
		logic [6:0] idx;
		ac97_pkg::cra_data_t data;	// Write data, or what a read returns
		bit head_chk;
	} cmd_t;

	typedef enum {ev_wr_done, ev_rd_done, ev_head, ev_sync_hi, ev_sync_lo} wait_ev_t;

	string ev_text [5] = '{"a write done pulse", "a read done pulse",
		"the codec to decode a frame head", "sync to rise", "sync to fall"};

	logic clk;
	logic rst;
	logic crac_we;
	logic [31:0] crac_out;
	ac97_pkg::cra_data_t crac_din;
	logic crac_wr_done;
	logic crac_rd_done;
	logic sync;
	logic sdata_out;
	logic sdata_in;
	int head_count;
	logic head_valid;
	logic head_wr;
	logic [6:0] head_idx;
	ac97_pkg::cra_data_t head_data;

	cmd_t cmds[$];
	ac97_pkg::cra_data_t last_din;
	bit din_known;
	bit timed_out;
	int test_errors;
	int pass_count;
	int fail_count;

	ac97_top dut (.clk(clk), .rst(rst), .crac_we(crac_we), .crac_out(crac_out),
		.crac_din(crac_din), .crac_wr_done(crac_wr_done), .crac_rd_done(crac_rd_done),
		.sync(sync), .sdata_out(sdata_out), .sdata_in(sdata_in));

	ac97_codec_model codec (.clk(clk), .rst(rst), .sync(sync), .sdata_out(sdata_out),
		.sdata_in(sdata_in), .head_count(head_count), .head_valid(head_valid),
		.head_wr(head_wr), .head_idx(head_idx), .head_data(head_data));

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_data(input string name, input string what,
		input ac97_pkg::cra_data_t exp, input ac97_pkg::cra_data_t act);
		if (act !== exp)
		begin
			$display("** Error %s %s: expected 0x%04h, actual 0x%04h", name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string name, input string what, input logic exp,
		input logic act);
		if (act !== exp)
		begin
			$display("** Error %s %s: expected %b, actual %b", name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_count(input string name, input string what, input int exp,
		input int act);
		if (act != exp)
		begin
			$display("** Error %s %s: expected %0d, actual %0d", name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0)
		begin
			$display("pass  %s", name);
			pass_count++;
		end
		else
		begin
			$display("fail  %s with %0d errors", name, test_errors);
			fail_count++;
		end
		test_errors = 0;
	endtask

	// Steps clk until the event, counting done pulses on the way
	task automatic wait_for(input string name, input wait_ev_t ev, output int cycles,
		inout int wr_seen, inout int rd_seen);
		int base;
		logic hit;
		base = head_count;
		cycles = 0;
		hit = 1'b0;
		while (!hit && cycles < 4 * ac97_pkg::frame_bits)
		begin
			@(negedge clk);
			cycles++;
			wr_seen += int'(crac_wr_done);
			rd_seen += int'(crac_rd_done);
			case (ev)
				ev_wr_done: hit = crac_wr_done;
				ev_rd_done: hit = crac_rd_done;
				ev_head: hit = head_count != base;
				ev_sync_hi: hit = sync;
				default: hit = !sync;
			endcase
		end
		if (!hit)
		begin
			$display("%s timed out after 4 frames waiting for %s", name, ev_text[ev]);
			timed_out = 1'b1;
			test_errors++;
		end
	endtask

	task automatic sync_after_reset();
		int cycles;
		int high;
		int low;
		int wr_seen;
		int rd_seen;
		wr_seen = 0;
		rd_seen = 0;
		@(negedge clk);
		check_flag("reset", "crac_wr_done", 1'b0, crac_wr_done);
		check_flag("reset", "crac_rd_done", 1'b0, crac_rd_done);
		check_flag("reset", "sync", 1'b0, sync);
		wait_for("reset", ev_sync_hi, cycles, wr_seen, rd_seen);
		wait_for("reset", ev_sync_lo, high, wr_seen, rd_seen);
		wait_for("reset", ev_sync_hi, low, wr_seen, rd_seen);
		check_count("reset", "sync high cycles", ac97_pkg::tag_bits, high);
		check_count("reset", "sync period", ac97_pkg::frame_bits, high + low);
		check_count("reset", "done pulses while idle", 0, wr_seen + rd_seen);
		finish_test("reset");
	endtask

	task automatic run_cmd(input cmd_t c);
		int cycles;
		int wr_seen;
		int rd_seen;
		wr_seen = 0;
		rd_seen = 0;
		@(posedge clk);
		crac_we <= 1'b1;
		crac_out <= {c.op == ac97_pkg::cra_read, 8'h00, c.idx,
			c.op == ac97_pkg::cra_write ? c.data : 16'h0000};
		@(posedge clk);
		crac_we <= 1'b0;
		if (c.op == ac97_pkg::cra_read)
		begin
			wait_for(c.name, ev_rd_done, cycles, wr_seen, rd_seen);
			check_data(c.name, "crac_din", c.data, crac_din);	// During the done pulse
			@(negedge clk);
			check_count(c.name, "crac_wr_done pulses", 0, wr_seen);
			check_flag(c.name, "crac_rd_done after pulse", 1'b0, crac_rd_done);
			last_din = c.data;
			din_known = 1'b1;
		end
		else
		begin
			wait_for(c.name, ev_wr_done, cycles, wr_seen, rd_seen);
			@(negedge clk);
			check_count(c.name, "crac_rd_done pulses", 0, rd_seen);
			if (din_known)
				check_data(c.name, "held crac_din", last_din, crac_din);
			if (c.head_chk && !timed_out)
			begin
				wait_for(c.name, ev_head, cycles, wr_seen, rd_seen);	// Frame carrying the write
				check_count(c.name, "crac_wr_done pulses", 1, wr_seen);
				check_flag(c.name, "tag bit 14", 1'b1, head_valid);
				check_flag(c.name, "tag bit 13", 1'b1, head_wr);
				check_data(c.name, "slot 1 index", 16'(c.idx), 16'(head_idx));
				check_data(c.name, "slot 2 data", c.data, head_data);
			end
		end
		finish_test(c.name);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Command table and main sequence

	initial
	begin
		ac97_pkg::cra_data_t data;
		logic [6:0] idx;
		int seed;
		rst = 1'b0;
		crac_we = 1'b0;
		crac_out = '0;
		seed = $urandom(32'h952);
		cmds.push_back('{"wr_02", ac97_pkg::cra_write, 7'h02, 16'h1234, 1'b1});
		cmds.push_back('{"wr_18", ac97_pkg::cra_write, 7'h18, 16'ha5c3, 1'b1});
		cmds.push_back('{"wr_2c", ac97_pkg::cra_write, 7'h2c, 16'h0ff0, 1'b1});
		cmds.push_back('{"wr_7e", ac97_pkg::cra_write, 7'h7e, 16'hffff, 1'b1});
		cmds.push_back('{"rd_02", ac97_pkg::cra_read, 7'h02, 16'h1234, 1'b0});
		cmds.push_back('{"rd_18", ac97_pkg::cra_read, 7'h18, 16'ha5c3, 1'b0});
		cmds.push_back('{"rd_2c", ac97_pkg::cra_read, 7'h2c, 16'h0ff0, 1'b0});
		cmds.push_back('{"rd_7e", ac97_pkg::cra_read, 7'h7e, 16'hffff, 1'b0});
		cmds.push_back('{"rd_40_unwritten", ac97_pkg::cra_read, 7'h40, 16'h0000, 1'b0});
		cmds.push_back('{"wr_18_again", ac97_pkg::cra_write, 7'h18, 16'h5a3c, 1'b1});
		// Issued right after the previous done pulse
		cmds.push_back('{"b2b_wr_26", ac97_pkg::cra_write, 7'h26, 16'h8001, 1'b0});
		cmds.push_back('{"b2b_rd_26", ac97_pkg::cra_read, 7'h26, 16'h8001, 1'b0});
		cmds.push_back('{"b2b_wr_38", ac97_pkg::cra_write, 7'h38, 16'h7fe1, 1'b0});
		cmds.push_back('{"b2b_rd_18", ac97_pkg::cra_read, 7'h18, 16'h5a3c, 1'b0});
		cmds.push_back('{"b2b_rd_38", ac97_pkg::cra_read, 7'h38, 16'h7fe1, 1'b0});
		for (int i = 0; i < 8; i++)
		begin
			idx = 7'($urandom());
			data = 16'($urandom());
			cmds.push_back('{$sformatf("rnd_wr_%0d", i), ac97_pkg::cra_write, idx, data, 1'b1});
			cmds.push_back('{$sformatf("rnd_rd_%0d", i), ac97_pkg::cra_read, idx, data, 1'b0});
		end
		repeat (16)
			@(posedge clk);
		rst <= 1'b1;
		sync_after_reset();
		foreach (cmds[i])
			if (!timed_out)
				run_cmd(cmds[i]);
		$display("%0d tests, %0d passed, %0d failed", pass_count + fail_count, pass_count,
			fail_count);
		if (fail_count == 0 && !timed_out)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- hdl/ac97_cra.sv
`timescale 1ns/1ps

module ac97_cra (
	input logic clk,
	input logic rst,
	input logic crac_we,
	input logic [31:0] crac_out,
	output ac97_pkg::cra_data_t crac_din,
	output logic crac_wr_done,
	output logic crac_rd_done,
	ac97_slot_if.cra slot
);

	ac97_pkg::cra_op_t op;
	logic crac_we_r;
	logic crac_wr;
	logic crac_rd;
	logic valid_r;
	logic valid_pe;
	logic valid_ne;
	logic rd_sent;
	logic rd_framed;

	assign op = ac97_pkg::cra_op_t'(crac_out[ac97_pkg::cmd_rd_bit]);

	// Slot 1 is the read flag and index, slot 2 the write data
	assign slot.out_slt1 = {crac_out[ac97_pkg::cmd_rd_bit],
		crac_out[ac97_pkg::cmd_idx_hi:ac97_pkg::cmd_idx_lo], 12'h000};
	assign slot.out_slt2 = {crac_out[15:0], 4'h0};

	assign slot.crac_wr = crac_wr;
	assign slot.crac_valid = crac_wr | crac_rd;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			valid_r <= 1'b1;	// Sequencer leaves reset with valid high
			crac_we_r <= 1'b0;
		end
		else
		begin
			valid_r <= slot.valid;
			crac_we_r <= crac_we;
		end
	end

	assign valid_pe = slot.valid & ~valid_r;
	assign valid_ne = ~slot.valid & valid_r;

	////////////////////////////////////////////////////////////////////////////
	// Write and read request flags

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			crac_wr <= 1'b0;
		else if (crac_we_r && op == ac97_pkg::cra_write)
			crac_wr <= 1'b1;
		else if (valid_ne)
			crac_wr <= 1'b0;	// Frame head already captured
	end

	assign crac_wr_done = crac_wr & valid_ne;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			crac_rd <= 1'b0;
		else if (crac_we_r && op == ac97_pkg::cra_read)
			crac_rd <= 1'b1;
		else if (rd_sent && valid_pe)
			crac_rd <= 1'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Read stages

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			rd_sent <= 1'b0;
			rd_framed <= 1'b0;
			crac_rd_done <= 1'b0;
		end
		else
		begin
			if (crac_rd && valid_ne)
				rd_sent <= 1'b1;
			else if (valid_pe)
				rd_sent <= 1'b0;
			if (rd_sent && valid_pe)
				rd_framed <= 1'b1;	// Reply frame starts
			else if (crac_rd_done)
				rd_framed <= 1'b0;
			crac_rd_done <= rd_framed & valid_pe;
		end
	end

	// Loaded on the same edge that raises the done pulse
	always_ff @(posedge clk)
	begin
		if (rd_framed && valid_pe)
			crac_din <= slot.in_slt2[ac97_pkg::slot_bits-1:4];
	end

	a_one_request: assert property (@(posedge clk) disable iff (!rst)
		!(crac_wr && crac_rd));
	a_wr_done_pulse: assert property (@(posedge clk) disable iff (!rst)
		crac_wr_done |=> !crac_wr_done);
	a_rd_done_pulse: assert property (@(posedge clk) disable iff (!rst)
		crac_rd_done |=> !crac_rd_done);
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst)
		crac_we |-> !slot.crac_valid);

endmodule

//--- hdl/ac97_frame_seq.sv
`timescale 1ns/1ps

module ac97_frame_seq (
	input logic clk,
	input logic rst,
	ac97_slot_if.seq slot,
	output logic sync
);

	ac97_pkg::bit_cnt_t cnt;
	logic last_bit;

	assign last_bit = cnt == ac97_pkg::bit_cnt_t'(ac97_pkg::frame_bits - 1);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			cnt <= '0;
		else if (last_bit)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Phase decode from slot boundaries

	always_comb
	begin
		if (cnt < ac97_pkg::bit_cnt_t'(ac97_pkg::slot1_start))
			slot.phase = ac97_pkg::ph_tag;
		else if (cnt < ac97_pkg::bit_cnt_t'(ac97_pkg::slot2_start))
			slot.phase = ac97_pkg::ph_slot1;
		else if (cnt < ac97_pkg::bit_cnt_t'(ac97_pkg::head_bits))
			slot.phase = ac97_pkg::ph_slot2;
		else if (cnt < ac97_pkg::bit_cnt_t'(ac97_pkg::gap_start))
			slot.phase = ac97_pkg::ph_data;
		else
			slot.phase = ac97_pkg::ph_gap;
	end

	assign slot.valid = cnt < ac97_pkg::bit_cnt_t'(ac97_pkg::gap_start);
	assign slot.load = cnt == ac97_pkg::bit_cnt_t'(ac97_pkg::gap_start);	// First gap bit

	// Sync follows the tag on the wire, so the frame after reset has none
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			sync <= 1'b0;
		else if (last_bit)
			sync <= 1'b1;
		else if (cnt == ac97_pkg::bit_cnt_t'(ac97_pkg::tag_bits - 1))
			sync <= 1'b0;
	end

	a_load_in_gap: assert property (@(posedge clk) disable iff (!rst)
		slot.load |-> $fell(slot.valid));

endmodule

//--- hdl/ac97_pkg.sv
package ac97_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Frame layout, one bit per clk

	localparam int unsigned frame_bits = 256;
	localparam int unsigned tag_bits = 16;
	localparam int unsigned slot_bits = 20;
	localparam int unsigned gap_start = 240;		// valid falls here

	localparam int unsigned slot1_start = tag_bits;
	localparam int unsigned slot2_start = tag_bits + slot_bits;
	localparam int unsigned head_bits = tag_bits + 2 * slot_bits;	// Tag plus slots 1 and 2

	////////////////////////////////////////////////////////////////////////////
	// Host command word

	localparam int unsigned cmd_rd_bit = 31;
	localparam int unsigned cmd_idx_hi = 22;
	localparam int unsigned cmd_idx_lo = 16;

	typedef logic [$clog2(frame_bits)-1:0] bit_cnt_t;
	typedef logic [$clog2(slot_bits)-1:0] slot_cnt_t;

	typedef logic [15:0] cra_data_t;

	typedef enum logic
	{
		cra_write = 1'b0,
		cra_read = 1'b1
	} cra_op_t;

	// Where the sequencer is within the frame
	typedef enum logic [2:0]
	{
		ph_tag,
		ph_slot1,
		ph_slot2,
		ph_data,
		ph_gap
	} frame_phase_t;

endpackage

//--- hdl/ac97_sin.sv
`timescale 1ns/1ps

module ac97_sin (
	input logic clk,
	input logic rst,
	ac97_slot_if.rx slot,
	input logic sdata_in
);

	logic [ac97_pkg::slot_bits-2:0] shift;
	ac97_pkg::slot_cnt_t bit_idx;
	logic last_bit;

	assign last_bit = slot.phase == ac97_pkg::ph_slot2 &&
		bit_idx == ac97_pkg::slot_cnt_t'(ac97_pkg::slot_bits - 1);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			bit_idx <= '0;
		else if (slot.load)
			bit_idx <= '0;	// Rearm for the next frame
		else if (slot.phase == ac97_pkg::ph_slot2)
			bit_idx <= bit_idx + 1'b1;
	end

	// Only slot 2 is of interest
	always_ff @(posedge clk)
	begin
		if (slot.phase == ac97_pkg::ph_slot2)
			shift <= {shift[ac97_pkg::slot_bits-3:0], sdata_in};
		if (last_bit)
			slot.in_slt2 <= {shift, sdata_in};
	end

endmodule

//--- hdl/ac97_slot_if.sv
`timescale 1ns/1ps

interface ac97_slot_if;

	// Frame timing
	logic valid;
	logic load;
	ac97_pkg::frame_phase_t phase;

	// Outgoing slots and tag flags
	logic [ac97_pkg::slot_bits-1:0] out_slt1;
	logic [ac97_pkg::slot_bits-1:0] out_slt2;
	logic crac_valid;
	logic crac_wr;

	logic [ac97_pkg::slot_bits-1:0] in_slt2;	// Last received slot 2

	modport cra (input valid, input in_slt2,
		output out_slt1, output out_slt2, output crac_valid, output crac_wr);
	modport seq (output valid, output load, output phase);
	modport tx (input load, input out_slt1, input out_slt2, input crac_valid, input crac_wr);
	modport rx (input load, input phase, output in_slt2);

endinterface

//--- hdl/ac97_sout.sv
`timescale 1ns/1ps

module ac97_sout (
	input logic clk,
	input logic rst,
	ac97_slot_if.tx slot,
	output logic sdata_out
);

	logic [ac97_pkg::head_bits-1:0] shadow;
	logic [ac97_pkg::head_bits-1:0] shift;
	ac97_pkg::bit_cnt_t gap_left;
	logic [ac97_pkg::tag_bits-1:0] tag;

	// Frame valid, then slot 1 and slot 2 valid on the command flags
	assign tag = {1'b1, slot.crac_valid, slot.crac_wr, 13'h0000};

	always_ff @(posedge clk)
	begin
		if (slot.load)
			shadow <= {tag, slot.out_slt1, slot.out_slt2};
	end

	////////////////////////////////////////////////////////////////////////////
	// Gap countdown to the frame wrap

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			gap_left <= '0;
		else if (slot.load)
			gap_left <= ac97_pkg::bit_cnt_t'(ac97_pkg::frame_bits - ac97_pkg::gap_start - 1);
		else if (gap_left != '0)
			gap_left <= gap_left - 1'b1;
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			shift <= '0;
		else if (gap_left == ac97_pkg::bit_cnt_t'(1))
			shift <= shadow;	// Bit 0 of the next frame
		else
			shift <= {shift[ac97_pkg::head_bits-2:0], 1'b0};
	end

	assign sdata_out = shift[ac97_pkg::head_bits-1];	// MSB first, zeros after slot 2

endmodule

//--- hdl/ac97_top.sv
`timescale 1ns/1ps

module ac97_top (
	input logic clk,
	input logic rst,
	input logic crac_we,
	input logic [31:0] crac_out,
	output ac97_pkg::cra_data_t crac_din,
	output logic crac_wr_done,
	output logic crac_rd_done,
	output logic sync,
	output logic sdata_out,
	input logic sdata_in
);

	ac97_slot_if slot ();

	ac97_cra u_cra (
		.clk (clk),
		.rst (rst),
		.crac_we (crac_we),
		.crac_out (crac_out),
		.crac_din (crac_din),
		.crac_wr_done (crac_wr_done),
		.crac_rd_done (crac_rd_done),
		.slot (slot.cra)
	);

	ac97_frame_seq u_frame_seq (
		.clk (clk),
		.rst (rst),
		.slot (slot.seq),
		.sync (sync)
	);

	// Serial link
	ac97_sout u_sout (
		.clk (clk),
		.rst (rst),
		.slot (slot.tx),
		.sdata_out (sdata_out)
	);

	ac97_sin u_sin (
		.clk (clk),
		.rst (rst),
		.slot (slot.rx),
		.sdata_in (sdata_in)
	);

endmodule

//--- project.f
hdl/ac97_pkg.sv
hdl/ac97_slot_if.sv
hdl/ac97_cra.sv
hdl/ac97_frame_seq.sv
hdl/ac97_sout.sv
hdl/ac97_sin.sv
hdl/ac97_top.sv
dv/ac97_codec_model.sv
dv/ac97_tb.sv
